//--- vlog.f
+incdir+rtl
rtl/noc_perf_pkg.sv
rtl/noc_perf_master_node.sv
rtl/noc_perf_link_buffer.sv
rtl/noc_perf_client_node.sv
rtl/noc_perf_top.sv
sim/noc_perf_tb.sv

//--- sim/noc_perf_tb.sv
/*
  Testbench for the link performance test: clock, reset, a table of
  rate and stall rows applied in a loop, result checks, watchdog and summary.
*/
`timescale 1ns/1ps
`include "noc_perf_settings.svh"

module noc_perf_tb
  import noc_perf_pkg::*;
  ();

  localparam int TOTAL = `NOC_PERF_TOTAL_COUNT;
  localparam int WARMUP = `NOC_PERF_WARMUP_COUNT;
  localparam int NUM_ROWS = 5;
  localparam int RESET_CYCLES = 5;
  localparam int POST_DONE_CYCLES = 40;
  localparam int CLK_PERIOD = 4;
  localparam longint WATCHDOG_CYCLES = NUM_ROWS * (TOTAL * 64 + 200);

  // each row holds an inject rate, a stall percentage and an exact-delay flag.
  typedef struct packed {
    logic [7:0] rate;
    logic [7:0] stall_pct;
    logic       exact_delay;
  } test_row_s;

  logic             link_clk_i;
  logic             link_reset_i;
  logic [7:0]       inject_rate_i;
  logic             client_stall_i;
  logic             done_o;
  noc_perf_result_s result_o;

  test_row_s   rows [NUM_ROWS];
  logic [31:0] rand_state;
  logic [7:0]  stall_pct;
  int          row_errors;
  int          pass_count;
  int          fail_count;

  noc_perf_top noc_perf_top_inst (
    .link_clk_i     (link_clk_i),
    .link_reset_i   (link_reset_i),
    .inject_rate_i  (inject_rate_i),
    .client_stall_i (client_stall_i),
    .done_o         (done_o),
    .result_o       (result_o)
  );

  always #(CLK_PERIOD / 2) link_clk_i = ~link_clk_i;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR: time %0t, %s: actual %0d, expected %0d", $time, name, actual,
               expected);
      row_errors++;
    end
  endtask

  // advance to the next falling edge and draw this cycle's stall level.
  task automatic step_cycle();
    @(negedge link_clk_i);
    if (stall_pct != 8'd0)
    begin
      rand_state     = next_random(rand_state);
      client_stall_i = ((rand_state % 100) < stall_pct);
    end
    else
      client_stall_i = 1'b0;
  endtask

  task automatic apply_reset();
    stall_pct      = 8'd0;
    client_stall_i = 1'b0;
    inject_rate_i  = 8'd0;
    link_reset_i   = 1'b1;
    repeat (RESET_CYCLES) step_cycle();
    link_reset_i = 1'b0;
    // no rising edge has passed since release, so the reset state is visible.
    check_value("done_o after reset", done_o, 0);
    check_value("result_o.received after reset", result_o.received, 0);
    check_value("result_o.total_delay after reset", result_o.total_delay, 0);
    check_value("result_o.finish_time after reset", result_o.finish_time, 0);
    check_value("result_o.seq_error after reset", result_o.seq_error, 0);
  endtask

  task automatic run_row(input int idx);
    test_row_s   row;
    logic [31:0] held_received;
    logic [31:0] held_finish;
    int          done_low_cycles;
    row        = rows[idx];
    row_errors = 0;
    apply_reset();
    inject_rate_i = row.rate;
    stall_pct     = row.stall_pct;
    while (done_o !== 1'b1)
      step_cycle();

    check_value("result_o.received", result_o.received, TOTAL);
    check_value("result_o.seq_error", result_o.seq_error, 0);
    if (row.exact_delay)
      check_value("result_o.total_delay", result_o.total_delay, TOTAL - WARMUP);
    else
      check_value("result_o.total_delay >= total minus warm-up",
                  result_o.total_delay >= (TOTAL - WARMUP), 1);
    check_value("result_o.finish_time >= total", result_o.finish_time >= TOTAL, 1);

    held_received   = result_o.received;
    held_finish     = result_o.finish_time;
    done_low_cycles = 0;
    repeat (POST_DONE_CYCLES)
    begin
      step_cycle();
      if (done_o !== 1'b1)
        done_low_cycles++;
    end
    check_value("done_o low cycles after done", done_low_cycles, 0);
    check_value("result_o.received after done", result_o.received, held_received);
    check_value("result_o.finish_time after done", result_o.finish_time, held_finish);

    if (row_errors == 0)
    begin
      pass_count++;
      $display("row %0d: rate %0d, stall %0d%%, delay %0d, finish %0d: PASS", idx, row.rate,
               row.stall_pct, result_o.total_delay, result_o.finish_time);
    end
    else
    begin
      fail_count++;
      $display("row %0d: rate %0d, stall %0d%%: FAIL with %0d errors", idx, row.rate,
               row.stall_pct, row_errors);
    end
  endtask

  initial
  begin
    link_clk_i     = 1'b0;
    link_reset_i   = 1'b1;
    inject_rate_i  = 8'd0;
    client_stall_i = 1'b0;
    stall_pct      = 8'd0;
    rand_state     = 32'h3166;
    pass_count     = 0;
    fail_count     = 0;

    rows[0] = {8'd255, 8'd0, 1'b1};  // full rate without back-pressure.
    rows[1] = {8'd32, 8'd0, 1'b1};   // sparse traffic still sees one cycle per flit.
    rows[2] = {8'd255, 8'd50, 1'b0};
    rows[3] = {8'd255, 8'd90, 1'b0};
    rows[4] = {8'd128, 8'd50, 1'b0};

    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);

    $display("rows passed: %0d, rows failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // the watchdog bounds the whole run by the flit count of every row.
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- rtl/noc_perf_top.sv
/*
  Top level of the link performance test: master node, link buffer
  and client node joined by ready/valid links.
*/
`timescale 1ns/1ps

module noc_perf_top
  import noc_perf_pkg::*;
  (
    input  logic             link_clk_i,
    input  logic             link_reset_i,
    input  logic [7:0]       inject_rate_i,
    input  logic             client_stall_i,
    output logic             done_o,
    output noc_perf_result_s result_o
  );

  noc_link_sif_s master_link_lo;  // valid and data from master to buffer.
  noc_link_sif_s master_link_li;  // ready from buffer to master.
  noc_link_sif_s client_link_li;  // valid and data from buffer to client.
  noc_link_sif_s client_link_lo;  // ready from client to buffer.

  noc_perf_master_node master_node (
    .link_clk_i    (link_clk_i),
    .link_reset_i  (link_reset_i),
    .inject_rate_i (inject_rate_i),
    .link_o        (master_link_lo),
    .link_i        (master_link_li)
  );

  noc_perf_link_buffer link_buffer (
    .link_clk_i   (link_clk_i),
    .link_reset_i (link_reset_i),
    .enq_link_i   (master_link_lo),
    .enq_link_o   (master_link_li),
    .deq_link_o   (client_link_li),
    .deq_link_i   (client_link_lo)
  );

  noc_perf_client_node client_node (
    .link_clk_i   (link_clk_i),
    .link_reset_i (link_reset_i),
    .stall_i      (client_stall_i),
    .link_i       (client_link_li),
    .link_o       (client_link_lo),
    .link_done_o  (done_o),
    .result_o     (result_o)
  );

endmodule

//--- rtl/noc_perf_client_node.sv
/*
  Measuring sink: counts received flits, sums per-flit delay after warm-up,
  checks sequence order and latches the result record at done.
*/
`timescale 1ns/1ps
`include "noc_perf_settings.svh"

module noc_perf_client_node
  import noc_perf_pkg::*;
  (
    input  logic             link_clk_i,
    input  logic             link_reset_i,
    input  logic             stall_i,
    input  noc_link_sif_s    link_i,
    output noc_link_sif_s    link_o,
    output logic             link_done_o,
    output noc_perf_result_s result_o
  );

  localparam int SEQ_W = `NOC_PERF_LINK_WIDTH - `NOC_PERF_STAMP_WIDTH;
  localparam int STAMP_W = `NOC_PERF_STAMP_WIDTH;
  localparam logic [31:0] WARMUP = 32'(`NOC_PERF_WARMUP_COUNT);
  localparam logic [31:0] TOTAL = 32'(`NOC_PERF_TOTAL_COUNT);

  logic [31:0]        cycle_r;
  logic [31:0]        received_r;
  logic [31:0]        total_delay_r;
  logic [31:0]        finish_r;
  logic [SEQ_W-1:0]   expected_r;
  logic               seq_error_r;
  logic               done_r;
  noc_flit_u          flit;
  logic               ready;
  logic               xfer;
  logic [STAMP_W-1:0] delay;

  assign ready = ~stall_i;
  assign xfer  = link_i.valid & ready;

  assign flit.raw = link_i.data;

  // the 16-bit subtraction wraps, so a stamp that wrapped still gives the right delay.
  assign delay = cycle_r[STAMP_W-1:0] - flit.fields.stamp;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      cycle_r       <= '0;
      received_r    <= '0;
      total_delay_r <= '0;
      finish_r      <= '0;
      expected_r    <= '0;
      seq_error_r   <= 1'b0;
      done_r        <= 1'b0;
    end
    else
    begin
      cycle_r <= cycle_r + 32'd1;
      // after done, flits are still taken but no longer counted.
      if (xfer && !done_r)
      begin
        received_r <= received_r + 32'd1;
        expected_r <= expected_r + SEQ_W'(1);
        if (received_r >= WARMUP)
          total_delay_r <= total_delay_r + 32'(delay);
        if (flit.fields.seq != expected_r)
          seq_error_r <= 1'b1;
        if (received_r + 32'd1 == TOTAL)
        begin
          done_r   <= 1'b1;
          finish_r <= cycle_r; // cycle of the final transfer.
        end
      end
    end
  end

  assign link_o.ready_and_rev = ready;
  assign link_o.valid         = 1'b0;
  assign link_o.data          = '0;

  assign link_done_o = done_r;

  assign result_o.received    = received_r;
  assign result_o.total_delay = total_delay_r;
  assign result_o.finish_time = finish_r;
  assign result_o.seq_error   = seq_error_r;

endmodule

//--- rtl/noc_perf_link_buffer.sv
/*
  Two-entry ready/valid link buffer between master and client.
  Keeps order and accepts at full rate while draining.
*/
`timescale 1ns/1ps
`include "noc_perf_settings.svh"

module noc_perf_link_buffer
  import noc_perf_pkg::*;
  (
    input  logic          link_clk_i,
    input  logic          link_reset_i,
    input  noc_link_sif_s enq_link_i,
    output noc_link_sif_s enq_link_o,
    output noc_link_sif_s deq_link_o,
    input  noc_link_sif_s deq_link_i
  );

  localparam int DEPTH = `NOC_PERF_BUFFER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`NOC_PERF_LINK_WIDTH-1:0] mem_r [DEPTH];
  logic [PTR_W-1:0]                wr_ptr_r;
  logic [PTR_W-1:0]                rd_ptr_r;
  logic [CNT_W-1:0]                count_r;
  logic                            full;
  logic                            empty;
  logic                            enq;
  logic                            deq;

  // pointer increment with wrap at the last entry.
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + PTR_W'(1);
  endfunction

  assign full  = (count_r == CNT_W'(DEPTH));
  assign empty = (count_r == '0);
  assign enq   = enq_link_i.valid & ~full;
  assign deq   = ~empty & deq_link_i.ready_and_rev;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ptr_next(wr_ptr_r);
      if (deq)
        rd_ptr_r <= ptr_next(rd_ptr_r);
      if (enq && !deq)
        count_r <= count_r + CNT_W'(1);
      else if (deq && !enq)
        count_r <= count_r - CNT_W'(1);
    end
  end

  always_ff @(posedge link_clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= enq_link_i.data;
  end

  // ready depends on occupancy only, never on the incoming valid.
  assign enq_link_o.ready_and_rev = ~full;
  assign enq_link_o.valid         = 1'b0;
  assign enq_link_o.data          = '0;

  assign deq_link_o.valid         = ~empty;
  assign deq_link_o.data          = mem_r[rd_ptr_r];
  assign deq_link_o.ready_and_rev = 1'b0;

endmodule

//--- rtl/noc_perf_master_node.sv
/*
  Traffic source: injects numbered, time-stamped flits at a rate set by
  an 8-bit threshold against an xorshift random byte.
*/
`timescale 1ns/1ps
`include "noc_perf_settings.svh"

module noc_perf_master_node
  import noc_perf_pkg::*;
  (
    input  logic          link_clk_i,
    input  logic          link_reset_i,
    input  logic [7:0]    inject_rate_i,
    output noc_link_sif_s link_o,
    input  noc_link_sif_s link_i
  );

  localparam int SEQ_W = `NOC_PERF_LINK_WIDTH - `NOC_PERF_STAMP_WIDTH;
  localparam logic [31:0] TOTAL = 32'(`NOC_PERF_TOTAL_COUNT);
  localparam logic [31:0] SEED = 32'h1d87_2b41;

  logic [31:0] cycle_r;
  logic [31:0] rand_r;
  logic [31:0] sent_r;
  logic        valid_r;
  noc_flit_u   flit_r;
  noc_flit_u   flit_next;
  logic        slot_free;
  logic        load;

  // one xorshift32 step.
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the output register can take a new flit when empty or draining this edge.
  assign slot_free = ~valid_r | link_i.ready_and_rev;
  assign load      = slot_free && (sent_r < TOTAL) && (rand_r[7:0] < inject_rate_i);

  always_comb
  begin
    flit_next.fields.seq   = sent_r[SEQ_W-1:0];
    // stamped with the cycle in which the flit first shows as valid.
    flit_next.fields.stamp = 16'(cycle_r + 32'd1);
  end

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      cycle_r <= '0;
      rand_r  <= SEED;
      sent_r  <= '0;
      valid_r <= 1'b0;
    end
    else
    begin
      cycle_r <= cycle_r + 32'd1;
      rand_r  <= xorshift32(rand_r);
      if (load)
      begin
        valid_r <= 1'b1;
        sent_r  <= sent_r + 32'd1;
      end
      else if (link_i.ready_and_rev)
        valid_r <= 1'b0; // last flit left and nothing new is offered.
    end
  end

  // payload register holds under back-pressure.
  always_ff @(posedge link_clk_i)
  begin
    if (load)
      flit_r <= flit_next;
  end

  assign link_o.valid         = valid_r;
  assign link_o.data          = flit_r.raw;
  assign link_o.ready_and_rev = 1'b0;

endmodule

//--- rtl/noc_perf_pkg.sv
/*
  Shared types: the ready/valid link bundle, the flit word with its
  sequence/stamp view, and the client result record.
*/
`include "noc_perf_settings.svh"

package noc_perf_pkg;

  // one bundle per direction; the receiver only drives ready_and_rev.
  typedef struct packed {
    logic                            valid;
    logic                            ready_and_rev;
    logic [`NOC_PERF_LINK_WIDTH-1:0] data;
  } noc_link_sif_s;

  // decoded view of a flit word. seq sits in the upper half.
  typedef struct packed {
    logic [`NOC_PERF_LINK_WIDTH-`NOC_PERF_STAMP_WIDTH-1:0] seq;
    logic [`NOC_PERF_STAMP_WIDTH-1:0]                      stamp;
  } noc_flit_fields_s;

  // the same word seen either raw or as seq and stamp.
  typedef union packed {
    logic [`NOC_PERF_LINK_WIDTH-1:0] raw;
    noc_flit_fields_s                fields;
  } noc_flit_u;

  typedef struct packed {
    logic [31:0] received;     // flits counted up to done.
    logic [31:0] total_delay;  // delay summed after warm-up.
    logic [31:0] finish_time;  // client cycle count at done.
    logic        seq_error;    // sticky.
  } noc_perf_result_s;

endpackage

//--- rtl/noc_perf_settings.svh
/*
  Build-time settings for the link performance test: link and stamp widths,
  warm-up and total flit counts, and link buffer depth.
*/
`ifndef NOC_PERF_SETTINGS_SVH
`define NOC_PERF_SETTINGS_SVH

// flit data width on the link.
`define NOC_PERF_LINK_WIDTH 32

// timestamp field in the low half of each flit.
`define NOC_PERF_STAMP_WIDTH 16

// flits received before delay is summed.
`define NOC_PERF_WARMUP_COUNT 8

// flits sent by the master and awaited by the client.
`define NOC_PERF_TOTAL_COUNT 64

// entries in the link buffer.
`define NOC_PERF_BUFFER_DEPTH 2

`endif
